// ==== list.f ====
+incdir+include
hdl/radar_rx_pkg.sv
hdl/radar_rx_regs.sv
hdl/radar_sample_fifo.sv
hdl/radar_rx_source.sv
hdl/radar_rx_drain.sv
hdl/radar_rx.sv
verif/radar_rx_tb.sv

// ==== verif/radar_rx_tb.sv ====
//////////////////////////////////////////////////
// radar rx testbench
// drives random I/Q and register traffic into the
// capture path and checks every output cycle
// against a model of the fifo and drain timing
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "radar_rx_consts.svh"

module radar_rx_tb;

   localparam int DEPTH = 1 << `RX_FIFO_AW;
   // stimulus cycles over all tests, rounded up
   localparam int STIM_CYCLES = 500;

   typedef enum {PH_IDLE, PH_REQ, PH_STB, PH_GAP} phase_t;

   logic        clk_i;
   logic        rst_n_i;
   logic        cfg_we_i;
   logic [1:0]  cfg_addr_i;
   logic [15:0] cfg_wdata_i;
   logic [15:0] cfg_rdata_o;
   logic [15:0] rx_in_i_i;
   logic [15:0] rx_in_q_i;
   logic [15:0] rx_i_o;
   logic [15:0] rx_q_o;
   logic        rx_strobe_o;

   // model of the fifo contents, the registers and the drain pacing
   logic [31:0] m_fifo[$];
   logic [31:0] m_out = 32'd0;
   logic [15:0] m_cnt = 16'd0;
   logic [3:0]  m_gap = `RX_GAP_RESET;
   logic [3:0]  m_gcnt = 4'd0;
   logic        m_cap = 1'b0;
   logic        m_dbg = 1'b0;
   logic        m_ovf = 1'b0;
   logic        m_strobe = 1'b0;
   logic        m_rd;
   logic        m_drop;
   phase_t      m_ph = PH_IDLE;
   int          m_sz;
   int          m_cyc = 0;

   int    errors = 0;
   int    checks = 0;
   int    n_strobe = 0;
   int    last_stb = -1;
   bit    pace_on = 1'b0;
   string test_name = "reset";

   radar_rx dut0
   (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .rx_in_i_i   (rx_in_i_i),
      .rx_in_q_i   (rx_in_q_i),
      .rx_i_o      (rx_i_o),
      .rx_q_o      (rx_q_o),
      .rx_strobe_o (rx_strobe_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // the model steps on the rising edge with the register values from before it
   always @(posedge clk_i)
   begin
      if (rst_n_i)
      begin
         m_cyc++;
         m_sz = m_fifo.size();
         m_rd = m_cap && (m_ph == PH_REQ);
         // drain goes idle, request, one strobe clock, then gap+1 clocks
         if (!m_cap)
         begin
            m_ph     = PH_IDLE;
            m_strobe = 1'b0;
         end
         else if (m_ph == PH_IDLE && m_sz != 0)
            m_ph = PH_REQ;
         else if (m_rd)
         begin
            // the oldest word reaches the outputs as the strobe rises
            m_out    = m_fifo.pop_front();
            m_strobe = 1'b1;
            m_ph     = PH_STB;
         end
         else if (m_ph == PH_STB)
         begin
            m_strobe = 1'b0;
            m_gcnt   = 4'd0;
            m_ph     = PH_GAP;
         end
         else if (m_ph == PH_GAP && m_gcnt >= m_gap)
            m_ph = PH_IDLE;
         else if (m_ph == PH_GAP)
            m_gcnt++;
         // a full fifo loses the write unless a read frees a slot on the same edge
         m_drop = m_cap && (m_sz >= DEPTH) && !m_rd;
         if (m_cap && !m_drop)
            m_fifo.push_back(m_dbg ? {m_cnt, `RX_DBG_MARKER} : {rx_in_i_i, rx_in_q_i});
         m_cnt = m_cap ? m_cnt + 16'd1 : 16'd0;
         // software writes land on this edge, and a drop outweighs a clear
         if (m_drop)
            m_ovf = 1'b1;
         else if (cfg_we_i && cfg_addr_i == `RX_REG_STATUS && cfg_wdata_i[0])
            m_ovf = 1'b0;
         if (cfg_we_i && cfg_addr_i == `RX_REG_CTRL)
         begin
            m_cap = cfg_wdata_i[0];
            m_dbg = cfg_wdata_i[1];
         end
         if (cfg_we_i && cfg_addr_i == `RX_REG_GAP)
            m_gap = cfg_wdata_i[3:0];
      end
   end

   task automatic log_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
   endtask

   // outputs settle after the rising edge and are compared on the falling edge
   always @(negedge clk_i)
   begin
      if (rst_n_i)
      begin
         checks++;
         if (rx_strobe_o !== m_strobe)
            log_mismatch("strobe", m_strobe, rx_strobe_o);
         // I and Q hold the last word read, strobed or not
         if ({rx_i_o, rx_q_o} !== m_out)
            log_mismatch("i/q word", m_out, {rx_i_o, rx_q_o});
         if (rx_strobe_o)
            n_strobe++;
         if (rx_strobe_o && pace_on && last_stb >= 0 && (m_cyc - last_stb) != m_gap + 4)
            log_mismatch("strobe spacing", m_gap + 4, m_cyc - last_stb);
         if (rx_strobe_o && pace_on)
            last_stb = m_cyc;
      end
   end

   // one clock of stimulus with fresh random I/Q
   task automatic tick();
      @(negedge clk_i);
      cfg_we_i  = 1'b0;
      rx_in_i_i = $urandom;
      rx_in_q_i = $urandom;
   endtask

   task automatic run_cycles(input int n);
      repeat (n) tick();
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
      tick();
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
   endtask

   // read-back is combinational from the address
   task automatic read_check(input logic [1:0] addr, input logic [15:0] exp,
                             input string what);
      tick();
      cfg_addr_i = addr;
      #1;
      checks++;
      if (cfg_rdata_o !== exp)
         log_mismatch(what, exp, cfg_rdata_o);
   endtask

   initial
   begin
      int         burst;
      int         strobes;
      logic [3:0] gap;

      void'($urandom(32'h95ba));
      rst_n_i     = 1'b0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = 2'd0;
      cfg_wdata_i = 16'd0;
      rx_in_i_i   = 16'd0;
      rx_in_q_i   = 16'd0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      // registers out of reset, then a quiet output with nothing captured
      read_check(`RX_REG_CTRL, 16'd0, "ctrl");
      read_check(`RX_REG_GAP, 16'd7, "gap");
      read_check(`RX_REG_STATUS, 16'd2, "status");
      run_cycles(50);

      test_name = "live";
      burst = 1 + ($urandom % 10);
      write_reg(`RX_REG_CTRL, 16'h0001);
      run_cycles(burst - 1);
      write_reg(`RX_REG_CTRL, 16'h0000);
      run_cycles(30);

      // two debug bursts, the count restarts at each enable
      test_name = "debug";
      write_reg(`RX_REG_CTRL, 16'h0003);
      run_cycles(8);
      write_reg(`RX_REG_CTRL, 16'h0000);
      run_cycles(5);
      write_reg(`RX_REG_CTRL, 16'h0003);
      run_cycles(8);
      write_reg(`RX_REG_CTRL, 16'h0000);

      // the gap is changed while the drain is parked and the fifo never runs dry here
      test_name = "pacing";
      gap = $urandom % 16;
      write_reg(`RX_REG_GAP, {12'd0, gap});
      pace_on = 1'b1;
      write_reg(`RX_REG_CTRL, 16'h0001);
      run_cycles(5 * (gap + 4));
      write_reg(`RX_REG_CTRL, 16'h0000);
      pace_on  = 1'b0;
      last_stb = -1;

      // earlier bursts may already have overflowed, so only this burst may set the flag
      test_name = "overflow";
      write_reg(`RX_REG_STATUS, 16'h0001);
      write_reg(`RX_REG_CTRL, 16'h0001);
      run_cycles(3 * DEPTH);
      write_reg(`RX_REG_CTRL, 16'h0000);
      read_check(`RX_REG_STATUS, 16'h0001, "overflow set");
      checks++;
      if (!m_ovf)
      begin
         errors++;
         $display("the model dropped no word in the overflow test");
      end
      write_reg(`RX_REG_STATUS, 16'h0001);
      read_check(`RX_REG_STATUS, 16'h0000, "overflow cleared");

      // a strobe may still fall on the disabling edge, so count from two clocks later
      test_name = "pause";
      write_reg(`RX_REG_CTRL, 16'h0001);
      run_cycles(25);
      write_reg(`RX_REG_CTRL, 16'h0000);
      run_cycles(2);
      #1;
      strobes = n_strobe;
      run_cycles(40);
      #1;
      checks++;
      if (n_strobe != strobes)
         log_mismatch("strobes while paused", strobes, n_strobe);
      write_reg(`RX_REG_CTRL, 16'h0001);
      run_cycles(40);
      write_reg(`RX_REG_CTRL, 16'h0000);
      run_cycles(5);

      $display("checks: %0d  strobes: %0d  errors: %0d", checks, n_strobe, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // the slowest drain slot is 15+4 clocks, so each stimulus cycle gets that long
   initial
   begin
      #(STIM_CYCLES * 19 * 20 + 1000);
      $display("watchdog expired before the tests finished, the run hung");
      $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== hdl/radar_rx.sv ====
//////////////////////////////////////////////////
// radar rx capture path
// top level joining the register block, sample
// source, sample fifo and read drain
//////////////////////////////////////////////////

`timescale 1ns/100ps

module radar_rx
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        cfg_we_i,
   input  logic [1:0]  cfg_addr_i,
   input  logic [15:0] cfg_wdata_i,
   output logic [15:0] cfg_rdata_o,
   input  logic [15:0] rx_in_i_i,
   input  logic [15:0] rx_in_q_i,
   output logic [15:0] rx_i_o,
   output logic [15:0] rx_q_o,
   output logic        rx_strobe_o
);

   import radar_rx_pkg::*;

   // control levels from the register block
   logic       cap_en;
   logic       dbg_mode;
   logic [3:0] rd_gap;

   // fifo write and read sides
   logic     wr_en;
   rx_word_t wr_word;
   logic     rd_en;
   rx_word_t rd_word;
   logic     fifo_empty;
   logic     fifo_drop;

   radar_rx_regs regs0
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cfg_we_i     (cfg_we_i),
      .cfg_addr_i   (cfg_addr_i),
      .cfg_wdata_i  (cfg_wdata_i),
      .cfg_rdata_o  (cfg_rdata_o),
      .fifo_drop_i  (fifo_drop),
      .fifo_empty_i (fifo_empty),
      .cap_en_o     (cap_en),
      .dbg_mode_o   (dbg_mode),
      .rd_gap_o     (rd_gap)
   );

   radar_rx_source source0
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .cap_en_i   (cap_en),
      .dbg_mode_i (dbg_mode),
      .rx_in_i_i  (rx_in_i_i),
      .rx_in_q_i  (rx_in_q_i),
      .wr_en_o    (wr_en),
      .wr_word_o  (wr_word)
   );

   // full only matters inside the fifo, overflow reaches software via the drop pulse
   radar_sample_fifo fifo0
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .wr_en_i   (wr_en),
      .wr_word_i (wr_word),
      .rd_en_i   (rd_en),
      .rd_word_o (rd_word),
      .empty_o   (fifo_empty),
      .full_o    (),
      .drop_o    (fifo_drop)
   );

   radar_rx_drain drain0
   (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cap_en_i     (cap_en),
      .rd_gap_i     (rd_gap),
      .fifo_empty_i (fifo_empty),
      .fifo_word_i  (rd_word),
      .fifo_rd_o    (rd_en),
      .rx_i_o       (rx_i_o),
      .rx_q_o       (rx_q_o),
      .rx_strobe_o  (rx_strobe_o)
   );

endmodule

// ==== hdl/radar_rx_drain.sv ====
//////////////////////////////////////////////////
// radar rx drain
// paces fifo reads, strobes each word out for one
// clock and then waits a programmable gap
//////////////////////////////////////////////////

`timescale 1ns/100ps

module radar_rx_drain
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   cap_en_i,
   input  logic [3:0]             rd_gap_i,
   input  logic                   fifo_empty_i,
   input  radar_rx_pkg::rx_word_t fifo_word_i,
   output logic                   fifo_rd_o,
   output logic [15:0]            rx_i_o,
   output logic [15:0]            rx_q_o,
   output logic                   rx_strobe_o
);

   // one-hot state encoding
   localparam logic [3:0] ST_IDLE   = 4'b0001;
   localparam logic [3:0] ST_REQ    = 4'b0010;
   localparam logic [3:0] ST_STROBE = 4'b0100;
   localparam logic [3:0] ST_GAP    = 4'b1000;

   logic [3:0] state;
   logic [3:0] gap_cnt;
   logic       rd_req;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state       <= ST_IDLE;
         gap_cnt     <= 4'd0;
         rd_req      <= 1'b0;
         rx_strobe_o <= 1'b0;
      end
      else if (!cap_en_i)
      begin
         // capture off parks the machine, fifo contents stay put
         state       <= ST_IDLE;
         gap_cnt     <= 4'd0;
         rd_req      <= 1'b0;
         rx_strobe_o <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (!fifo_empty_i)
               begin
                  rd_req <= 1'b1;
                  state  <= ST_REQ;
               end
            end
            // fifo loads its output register on this edge
            ST_REQ:
            begin
               rd_req      <= 1'b0;
               rx_strobe_o <= 1'b1;
               state       <= ST_STROBE;
            end
            ST_STROBE:
            begin
               rx_strobe_o <= 1'b0;
               gap_cnt     <= 4'd0;
               state       <= ST_GAP;
            end
            // gap lasts rd_gap+1 clocks, >= keeps a shrunk gap from wrapping
            ST_GAP:
            begin
               if (gap_cnt >= rd_gap_i)
               begin
                  gap_cnt <= 4'd0;
                  state   <= ST_IDLE;
               end
               else
                  gap_cnt <= gap_cnt + 4'd1;
            end
            default:
            begin
               rd_req      <= 1'b0;
               rx_strobe_o <= 1'b0;
               state       <= ST_IDLE;
            end
         endcase
      end
   end

   // a request pending as capture drops must not pop a word that would never be strobed
   assign fifo_rd_o = rd_req && cap_en_i;

   // output data is the fifo read register, held until the next pop
   assign rx_i_o = fifo_word_i.iq.i;
   assign rx_q_o = fifo_word_i.iq.q;

   // each word is presented for exactly one clock
   a_strobe_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rx_strobe_o |=> !rx_strobe_o)
      else $error("rx_strobe_o high on two consecutive cycles");

endmodule

// ==== hdl/radar_rx_source.sv ====
//////////////////////////////////////////////////
// radar rx sample source
// forms one fifo word per enabled clock, either
// from live I/Q or from a debug count and marker
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "radar_rx_consts.svh"

module radar_rx_source
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   cap_en_i,
   input  logic                   dbg_mode_i,
   input  logic [15:0]            rx_in_i_i,
   input  logic [15:0]            rx_in_q_i,
   output logic                   wr_en_o,
   output radar_rx_pkg::rx_word_t wr_word_o
);

   logic [15:0] dbg_cnt;

   // count is zero on the first enabled cycle and steps every enabled cycle
   // whether or not the fifo accepts the word
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         dbg_cnt <= 16'd0;
      else if (!cap_en_i)
         dbg_cnt <= 16'd0;
      else
         dbg_cnt <= dbg_cnt + 16'd1;
   end

   // one write per clock for as long as capture is on
   assign wr_en_o = cap_en_i;

   always_comb
   begin
      if (dbg_mode_i)
      begin
         wr_word_o.dbg.count  = dbg_cnt;
         wr_word_o.dbg.marker = `RX_DBG_MARKER;
      end
      else
      begin
         wr_word_o.iq.i = rx_in_i_i;
         wr_word_o.iq.q = rx_in_q_i;
      end
   end

endmodule

// ==== hdl/radar_sample_fifo.sv ====
//////////////////////////////////////////////////
// radar sample fifo
// circular buffer of rx words with registered
// read data, empty and full flags, and a pulse
// for each write that finds no free slot
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "radar_rx_consts.svh"

module radar_sample_fifo
#(
   parameter int ADDR_W = `RX_FIFO_AW
)
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   wr_en_i,
   input  radar_rx_pkg::rx_word_t wr_word_i,
   input  logic                   rd_en_i,
   output radar_rx_pkg::rx_word_t rd_word_o,
   output logic                   empty_o,
   output logic                   full_o,
   output logic                   drop_o
);

   import radar_rx_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   // storage array for the sample words
   rx_word_t mem [DEPTH];

   // pointers carry one extra bit to tell full from empty
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;
   logic [ADDR_W:0] level;
   logic            do_wr;
   logic            do_rd;

   // equal pointers mean empty, same index on opposite laps means full
   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                    (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   // occupancy, wraps correctly because of the extra pointer bit
   assign level = wr_ptr - rd_ptr;

   assign do_rd = rd_en_i && !empty_o;

   // a read in the same cycle frees a slot, so a full fifo still takes the write
   assign do_wr  = wr_en_i && (!full_o || do_rd);
   assign drop_o = wr_en_i && !do_wr;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // write port
   always_ff @(posedge clk_i)
   begin
      if (do_wr)
         mem[wr_ptr[ADDR_W-1:0]] <= wr_word_i;
   end

   // the oldest word lands in the output register on the read edge
   // and stays there until the next read
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         rd_word_o <= '0;
      else if (do_rd)
         rd_word_o <= mem[rd_ptr[ADDR_W-1:0]];
   end

   // the drain only asks for a word once it has seen the fifo non-empty
   a_no_rd_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rd_en_i |-> !empty_o)
      else $error("read requested while fifo is empty");

   // one write and one read per cycle at most, so fill moves by one step
   a_level_step: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (level == $past(level)) ||
      (level == $past(level) + 1'b1) ||
      (level == $past(level) - 1'b1))
      else $error("fifo occupancy jumped by more than one");

endmodule

// ==== hdl/radar_rx_regs.sv ====
//////////////////////////////////////////////////
// radar rx configuration and status registers
// holds capture enable, debug mode and read gap,
// and keeps a sticky flag for fifo overflow
//////////////////////////////////////////////////

`timescale 1ns/100ps

`include "radar_rx_consts.svh"

module radar_rx_regs
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        cfg_we_i,
   input  logic [1:0]  cfg_addr_i,
   input  logic [15:0] cfg_wdata_i,
   output logic [15:0] cfg_rdata_o,
   input  logic        fifo_drop_i,
   input  logic        fifo_empty_i,
   output logic        cap_en_o,
   output logic        dbg_mode_o,
   output logic [3:0]  rd_gap_o
);

   logic wr_ctrl;
   logic wr_gap;
   logic wr_status;
   logic ovf;

   // address decode of the write strobe
   assign wr_ctrl   = cfg_we_i && (cfg_addr_i == `RX_REG_CTRL);
   assign wr_gap    = cfg_we_i && (cfg_addr_i == `RX_REG_GAP);
   assign wr_status = cfg_we_i && (cfg_addr_i == `RX_REG_STATUS);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         cap_en_o   <= 1'b0;
         dbg_mode_o <= 1'b0;
         rd_gap_o   <= `RX_GAP_RESET;
         ovf        <= 1'b0;
      end
      else
      begin
         if (wr_ctrl)
         begin
            cap_en_o   <= cfg_wdata_i[0];
            dbg_mode_o <= cfg_wdata_i[1];
         end
         if (wr_gap)
            rd_gap_o <= cfg_wdata_i[3:0];
         // a drop in the same cycle as a clear keeps the flag set
         if (fifo_drop_i)
            ovf <= 1'b1;
         else if (wr_status && cfg_wdata_i[0])
            ovf <= 1'b0;
      end
   end

   // read-back follows the address with no register stage
   always_comb
   begin
      case (cfg_addr_i)
         `RX_REG_CTRL:   cfg_rdata_o = {14'd0, dbg_mode_o, cap_en_o};
         `RX_REG_GAP:    cfg_rdata_o = {12'd0, rd_gap_o};
         `RX_REG_STATUS: cfg_rdata_o = {14'd0, fifo_empty_i, ovf};
         default:        cfg_rdata_o = 16'd0;
      endcase
   end

   // the drain pacing may only move when software writes the gap register
   a_gap_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !wr_gap |=> $stable(rd_gap_o))
      else $error("rd_gap_o changed without a write to GAP");

endmodule

// ==== hdl/radar_rx_pkg.sv ====
//////////////////////////////////////////////////
// radar rx package
// types for the 32-bit sample fifo word, which is
// read either as an I/Q pair or as a debug word
//////////////////////////////////////////////////

package radar_rx_pkg;

   // live sample view, I in the upper half and Q in the lower half
   typedef struct packed {
      logic [15:0] i;
      logic [15:0] q;
   } rx_iq_t;

   // debug view, running count on top of the fixed marker
   typedef struct packed {
      logic [15:0] count;
      logic [15:0] marker;
   } rx_dbg_t;

   // one fifo word with both decodings laid over the same bits
   typedef union packed {
      rx_iq_t  iq;
      rx_dbg_t dbg;
   } rx_word_t;

endpackage

// ==== include/radar_rx_consts.svh ====
//////////////////////////////////////////////////
// radar rx constants
// sizes, register map and fixed values shared by
// the capture path and its testbench
//////////////////////////////////////////////////

`ifndef RADAR_RX_CONSTS_SVH
`define RADAR_RX_CONSTS_SVH

// fifo address width, depth is two to this power
`define RX_FIFO_AW 4

// marker placed in the low half of every debug word
`define RX_DBG_MARKER 16'hAA55

// register addresses on the configuration port
`define RX_REG_CTRL 2'd0
`define RX_REG_GAP 2'd1
`define RX_REG_STATUS 2'd2

// read gap out of reset keeps the old fixed pacing
`define RX_GAP_RESET 4'd7

`endif
